/* source/gat_debug_pkg.sv */
`default_nettype none

package gat_debug_pkg;

  // identification values shown in the ID register
  localparam logic [31:0] H_NUM_SPARSE_DATA = 32'd12;
  localparam logic [31:0] BUILD_ID          = 32'd20030;

  localparam int NUM_SPPE_LANES = 16;
  localparam int SPPE_W         = 12;
  localparam int CAPTURE_LANE   = 2;

  localparam int WH_ADDR_W   = 14;
  localparam int FEAT_ADDR_W = 16;

  localparam logic [15:0] FEAT_THRESHOLD_RST = 16'd43328;

  localparam int CNT_W     = 64;
  localparam int NUM_FLAGS = 9;

  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;

  // watched weight addresses after reset
  localparam logic [WH_ADDR_W-1:0] CAP_ADDR_A_RST = 14'd10;
  localparam logic [WH_ADDR_W-1:0] CAP_ADDR_B_RST = 14'd20;

  // bit positions inside the CTRL word
  localparam int CTRL_CLR_FLAGS = 0;
  localparam int CTRL_CLR_COUNT = 1;
  localparam int CTRL_CLR_CAP   = 2;

  typedef enum int unsigned {
    SPMM_VLD   = 0,
    SPMM_RDY   = 1,
    DMVM_VLD   = 2,
    DMVM_RDY   = 3,
    SM_VLD     = 4,
    SM_RDY     = 5,
    AGGR_VLD   = 6,
    AGGR_RDY   = 7,
    FEAT_RANGE = 8
  } flag_idx_e;

  typedef enum logic [7:0] {
    ID         = 8'h00,
    FLAGS      = 8'h04,
    SMCNT_LO   = 8'h08,
    SMCNT_HI   = 8'h0C,
    CAP_A      = 8'h10,
    CAP_B      = 8'h14,
    CAP_ADDR_A = 8'h18,
    CAP_ADDR_B = 8'h1C,
    FEAT_THR   = 8'h20,
    CTRL       = 8'h24
  } reg_addr_e;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic {R_IDLE, R_DATA} rd_state_e;
  typedef enum logic {W_IDLE, W_RESP} wr_state_e;

endpackage

`default_nettype wire

/* source/debug_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface debug_bus_if;

  // monitor results
  logic [gat_debug_pkg::NUM_FLAGS-1:0]   flags;
  logic [gat_debug_pkg::CNT_W-1:0]       sm_count;
  logic [31:0]                           cap_a;
  logic [31:0]                           cap_b;

  // settings and one-cycle clear pulses from the register file
  logic [gat_debug_pkg::WH_ADDR_W-1:0]   cap_addr_a;
  logic [gat_debug_pkg::WH_ADDR_W-1:0]   cap_addr_b;
  logic [gat_debug_pkg::FEAT_ADDR_W-1:0] feat_thr;
  logic                                  clr_flags;
  logic                                  clr_count;
  logic                                  clr_cap;

  modport mon (
    output flags, sm_count, cap_a, cap_b,
    input  cap_addr_a, cap_addr_b, feat_thr,
    input  clr_flags, clr_count, clr_cap
  );

  modport regs (
    input  flags, sm_count, cap_a, cap_b,
    output cap_addr_a, cap_addr_b, feat_thr,
    output clr_flags, clr_count, clr_cap
  );

endinterface

`default_nettype wire

/* source/stage_flag_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module stage_flag_monitor (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   spmm_vld_i,
  input  wire                                   spmm_rdy_i,
  input  wire                                   dmvm_vld_i,
  input  wire                                   dmvm_rdy_i,
  input  wire                                   sm_vld_i,
  input  wire                                   sm_rdy_i,
  input  wire                                   aggr_vld_i,
  input  wire                                   aggr_rdy_i,
  input  wire                                   feat_bram_ena_i,
  input  wire  [gat_debug_pkg::FEAT_ADDR_W-1:0] feat_bram_addra_i,
  debug_bus_if.mon                              bus
);

  logic [gat_debug_pkg::NUM_FLAGS-1:0] seen;
  logic [gat_debug_pkg::NUM_FLAGS-1:0] flags_q;
  logic                                feat_hit;

  assign feat_hit = feat_bram_ena_i && (feat_bram_addra_i >= bus.feat_thr);

  always_comb begin
    seen[gat_debug_pkg::SPMM_VLD]   = spmm_vld_i;
    seen[gat_debug_pkg::SPMM_RDY]   = spmm_rdy_i;
    seen[gat_debug_pkg::DMVM_VLD]   = dmvm_vld_i;
    seen[gat_debug_pkg::DMVM_RDY]   = dmvm_rdy_i;
    seen[gat_debug_pkg::SM_VLD]     = sm_vld_i;
    seen[gat_debug_pkg::SM_RDY]     = sm_rdy_i;
    seen[gat_debug_pkg::AGGR_VLD]   = aggr_vld_i;
    seen[gat_debug_pkg::AGGR_RDY]   = aggr_rdy_i;
    seen[gat_debug_pkg::FEAT_RANGE] = feat_hit;
  end

  // each bit holds once seen; an input that is high during a clear keeps its bit set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else if (bus.clr_flags) begin
      flags_q <= seen;
    end else begin
      flags_q <= flags_q | seen;
    end
  end

  assign bus.flags = flags_q;

endmodule

`default_nettype wire

/* source/sppe_event_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module sppe_event_monitor (
  input  wire                                       clk,
  input  wire                                       rst_n,
  input  wire                                       sm_vld_i,
  input  wire                                       spmm_rdy_i,
  input  wire [gat_debug_pkg::WH_ADDR_W-1:0]        wh_bram_addra_i,
  input  wire [gat_debug_pkg::NUM_SPPE_LANES-1:0]
              [gat_debug_pkg::SPPE_W-1:0]           sppe_i,
  debug_bus_if.mon                                  bus
);

  logic [gat_debug_pkg::CNT_W-1:0]     count_q;
  logic [gat_debug_pkg::SPPE_W-1:0]    lane;
  logic [gat_debug_pkg::WH_ADDR_W-1:0] watch_addr [2];
  logic [31:0]                         cap_q [2];
  logic [1:0]                          match;

  assign lane          = sppe_i[gat_debug_pkg::CAPTURE_LANE];
  assign watch_addr[0] = bus.cap_addr_a;
  assign watch_addr[1] = bus.cap_addr_b;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      match[i] = spmm_rdy_i && (wh_bram_addra_i == watch_addr[i]);
    end
  end

  // a softmax cycle that coincides with a clear is counted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (bus.clr_count) begin
      count_q <= {{(gat_debug_pkg::CNT_W-1){1'b0}}, sm_vld_i};
    end else if (sm_vld_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2; i++) begin
        cap_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (match[i]) begin
          cap_q[i] <= {{(32-gat_debug_pkg::SPPE_W){1'b0}}, lane};
        end else if (bus.clr_cap) begin
          cap_q[i] <= '0;
        end
      end
    end
  end

  assign bus.sm_count = count_q;
  assign bus.cap_a    = cap_q[0];
  assign bus.cap_b    = cap_q[1];

endmodule

`default_nettype wire

/* source/debug_axil_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_axil_regs (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire  [gat_debug_pkg::AXIL_ADDR_W-1:0] s_awaddr_i,
  input  wire                                   s_awvalid_i,
  output logic                                  s_awready_o,
  input  wire  [gat_debug_pkg::AXIL_DATA_W-1:0] s_wdata_i,
  input  wire  [3:0]                            s_wstrb_i,
  input  wire                                   s_wvalid_i,
  output logic                                  s_wready_o,
  output logic [1:0]                            s_bresp_o,
  output logic                                  s_bvalid_o,
  input  wire                                   s_bready_i,
  input  wire  [gat_debug_pkg::AXIL_ADDR_W-1:0] s_araddr_i,
  input  wire                                   s_arvalid_i,
  output logic                                  s_arready_o,
  output logic [gat_debug_pkg::AXIL_DATA_W-1:0] s_rdata_o,
  output logic [1:0]                            s_rresp_o,
  output logic                                  s_rvalid_o,
  input  wire                                   s_rready_i,
  debug_bus_if.regs                             bus
);

  gat_debug_pkg::rd_state_e            rd_state;
  gat_debug_pkg::wr_state_e            wr_state;
  gat_debug_pkg::reg_addr_e            rd_addr;
  gat_debug_pkg::reg_addr_e            wr_addr;
  gat_debug_pkg::axi_resp_e            rd_resp;
  gat_debug_pkg::axi_resp_e            wr_resp;
  gat_debug_pkg::axi_resp_e            rresp_q;
  gat_debug_pkg::axi_resp_e            bresp_q;
  logic [gat_debug_pkg::AXIL_DATA_W-1:0] rd_word;
  logic [gat_debug_pkg::AXIL_DATA_W-1:0] rdata_q;
  logic                                rd_fire;
  logic                                wr_fire;
  logic [gat_debug_pkg::WH_ADDR_W-1:0]   cap_addr_a_q;
  logic [gat_debug_pkg::WH_ADDR_W-1:0]   cap_addr_b_q;
  logic [gat_debug_pkg::FEAT_ADDR_W-1:0] feat_thr_q;
  logic                                clr_flags_q;
  logic                                clr_count_q;
  logic                                clr_cap_q;

  assign rd_addr = gat_debug_pkg::reg_addr_e'(s_araddr_i);
  assign wr_addr = gat_debug_pkg::reg_addr_e'(s_awaddr_i);

  assign s_arready_o = (rd_state == gat_debug_pkg::R_IDLE);
  assign rd_fire     = s_arvalid_i && s_arready_o;
  // address and data are taken together, so both readies rise in the same cycle
  assign wr_fire     = (wr_state == gat_debug_pkg::W_IDLE) && s_awvalid_i && s_wvalid_i;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;
  assign s_rvalid_o  = (rd_state == gat_debug_pkg::R_DATA);
  assign s_bvalid_o  = (wr_state == gat_debug_pkg::W_RESP);
  assign s_rdata_o   = rdata_q;
  assign s_rresp_o   = rresp_q;
  assign s_bresp_o   = bresp_q;

  always_comb begin
    rd_word = '0;
    rd_resp = gat_debug_pkg::OKAY;
    case (rd_addr)
      gat_debug_pkg::ID:
        rd_word = {gat_debug_pkg::H_NUM_SPARSE_DATA[15:0], gat_debug_pkg::BUILD_ID[15:0]};
      gat_debug_pkg::FLAGS:      rd_word = {{(32-gat_debug_pkg::NUM_FLAGS){1'b0}}, bus.flags};
      gat_debug_pkg::SMCNT_LO:   rd_word = bus.sm_count[31:0];
      gat_debug_pkg::SMCNT_HI:   rd_word = bus.sm_count[63:32];
      gat_debug_pkg::CAP_A:      rd_word = bus.cap_a;
      gat_debug_pkg::CAP_B:      rd_word = bus.cap_b;
      gat_debug_pkg::CAP_ADDR_A: rd_word = {{(32-gat_debug_pkg::WH_ADDR_W){1'b0}}, cap_addr_a_q};
      gat_debug_pkg::CAP_ADDR_B: rd_word = {{(32-gat_debug_pkg::WH_ADDR_W){1'b0}}, cap_addr_b_q};
      gat_debug_pkg::FEAT_THR:   rd_word = {{(32-gat_debug_pkg::FEAT_ADDR_W){1'b0}}, feat_thr_q};
      gat_debug_pkg::CTRL:       rd_word = '0;
      default:                   rd_resp = gat_debug_pkg::SLVERR;
    endcase
  end

  always_comb begin
    case (wr_addr)
      gat_debug_pkg::CAP_ADDR_A,
      gat_debug_pkg::CAP_ADDR_B,
      gat_debug_pkg::FEAT_THR,
      gat_debug_pkg::CTRL:       wr_resp = gat_debug_pkg::OKAY;
      default:                   wr_resp = gat_debug_pkg::SLVERR;
    endcase
  end

  // writes are whole words, s_wstrb_i does not mask any byte
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_addr_a_q <= gat_debug_pkg::CAP_ADDR_A_RST;
      cap_addr_b_q <= gat_debug_pkg::CAP_ADDR_B_RST;
      feat_thr_q   <= gat_debug_pkg::FEAT_THRESHOLD_RST;
      clr_flags_q  <= 1'b0;
      clr_count_q  <= 1'b0;
      clr_cap_q    <= 1'b0;
    end else begin
      clr_flags_q <= 1'b0;
      clr_count_q <= 1'b0;
      clr_cap_q   <= 1'b0;
      if (wr_fire) begin
        case (wr_addr)
          gat_debug_pkg::CAP_ADDR_A: cap_addr_a_q <= s_wdata_i[gat_debug_pkg::WH_ADDR_W-1:0];
          gat_debug_pkg::CAP_ADDR_B: cap_addr_b_q <= s_wdata_i[gat_debug_pkg::WH_ADDR_W-1:0];
          gat_debug_pkg::FEAT_THR:   feat_thr_q   <= s_wdata_i[gat_debug_pkg::FEAT_ADDR_W-1:0];
          gat_debug_pkg::CTRL: begin
            clr_flags_q <= s_wdata_i[gat_debug_pkg::CTRL_CLR_FLAGS];
            clr_count_q <= s_wdata_i[gat_debug_pkg::CTRL_CLR_COUNT];
            clr_cap_q   <= s_wdata_i[gat_debug_pkg::CTRL_CLR_CAP];
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= gat_debug_pkg::R_IDLE;
      wr_state <= gat_debug_pkg::W_IDLE;
    end else begin
      if (rd_fire) begin
        rd_state <= gat_debug_pkg::R_DATA;
      end else if (s_rvalid_o && s_rready_i) begin
        rd_state <= gat_debug_pkg::R_IDLE;
      end
      if (wr_fire) begin
        wr_state <= gat_debug_pkg::W_RESP;
      end else if (s_bvalid_o && s_bready_i) begin
        wr_state <= gat_debug_pkg::W_IDLE;
      end
    end
  end

  // the response payload is loaded at each address handshake
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
    if (wr_fire) begin
      bresp_q <= wr_resp;
    end
  end

  assign bus.cap_addr_a = cap_addr_a_q;
  assign bus.cap_addr_b = cap_addr_b_q;
  assign bus.feat_thr   = feat_thr_q;
  assign bus.clr_flags  = clr_flags_q;
  assign bus.clr_count  = clr_count_q;
  assign bus.clr_cap    = clr_cap_q;

endmodule

`default_nettype wire

/* source/gat_debugger_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gat_debugger_top (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   spmm_vld_i,
  input  wire                                   spmm_rdy_i,
  input  wire                                   dmvm_vld_i,
  input  wire                                   dmvm_rdy_i,
  input  wire                                   sm_vld_i,
  input  wire                                   sm_rdy_i,
  input  wire                                   aggr_vld_i,
  input  wire                                   aggr_rdy_i,
  input  wire  [gat_debug_pkg::WH_ADDR_W-1:0]   wh_bram_addra_i,
  input  wire  [gat_debug_pkg::NUM_SPPE_LANES-1:0]
               [gat_debug_pkg::SPPE_W-1:0]      sppe_i,
  input  wire                                   feat_bram_ena_i,
  input  wire  [gat_debug_pkg::FEAT_ADDR_W-1:0] feat_bram_addra_i,
  input  wire  [gat_debug_pkg::AXIL_ADDR_W-1:0] s_awaddr_i,
  input  wire                                   s_awvalid_i,
  output logic                                  s_awready_o,
  input  wire  [gat_debug_pkg::AXIL_DATA_W-1:0] s_wdata_i,
  input  wire  [3:0]                            s_wstrb_i,
  input  wire                                   s_wvalid_i,
  output logic                                  s_wready_o,
  output logic [1:0]                            s_bresp_o,
  output logic                                  s_bvalid_o,
  input  wire                                   s_bready_i,
  input  wire  [gat_debug_pkg::AXIL_ADDR_W-1:0] s_araddr_i,
  input  wire                                   s_arvalid_i,
  output logic                                  s_arready_o,
  output logic [gat_debug_pkg::AXIL_DATA_W-1:0] s_rdata_o,
  output logic [1:0]                            s_rresp_o,
  output logic                                  s_rvalid_o,
  input  wire                                   s_rready_i
);

  debug_bus_if bus ();

  stage_flag_monitor u_flags (
    .clk               (clk),
    .rst_n             (rst_n),
    .spmm_vld_i        (spmm_vld_i),
    .spmm_rdy_i        (spmm_rdy_i),
    .dmvm_vld_i        (dmvm_vld_i),
    .dmvm_rdy_i        (dmvm_rdy_i),
    .sm_vld_i          (sm_vld_i),
    .sm_rdy_i          (sm_rdy_i),
    .aggr_vld_i        (aggr_vld_i),
    .aggr_rdy_i        (aggr_rdy_i),
    .feat_bram_ena_i   (feat_bram_ena_i),
    .feat_bram_addra_i (feat_bram_addra_i),
    .bus               (bus.mon)
  );

  sppe_event_monitor u_events (
    .clk             (clk),
    .rst_n           (rst_n),
    .sm_vld_i        (sm_vld_i),
    .spmm_rdy_i      (spmm_rdy_i),
    .wh_bram_addra_i (wh_bram_addra_i),
    .sppe_i          (sppe_i),
    .bus             (bus.mon)
  );

  debug_axil_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .bus         (bus.regs)
  );

endmodule

`default_nettype wire

/* test/tb_gat_debugger.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gat_debugger;

  // about five times the length of all tests together
  localparam int TIMEOUT_CYCLES = 2000;
  // upper half is the sparse-data count 12, lower half is build 20030
  localparam logic [31:0] ID_EXP = {16'd12, 16'd20030};

  logic                    clk;
  logic                    rst_n;
  logic                    spmm_vld_i;
  logic                    spmm_rdy_i;
  logic                    dmvm_vld_i;
  logic                    dmvm_rdy_i;
  logic                    sm_vld_i;
  logic                    sm_rdy_i;
  logic                    aggr_vld_i;
  logic                    aggr_rdy_i;
  logic [13:0]             wh_bram_addra_i;
  logic [15:0][11:0]       sppe_i;
  logic                    feat_bram_ena_i;
  logic [15:0]             feat_bram_addra_i;
  logic [7:0]              s_awaddr_i;
  logic                    s_awvalid_i;
  logic                    s_awready_o;
  logic [31:0]             s_wdata_i;
  logic [3:0]              s_wstrb_i;
  logic                    s_wvalid_i;
  logic                    s_wready_o;
  logic [1:0]              s_bresp_o;
  logic                    s_bvalid_o;
  logic                    s_bready_i;
  logic [7:0]              s_araddr_i;
  logic                    s_arvalid_i;
  logic                    s_arready_o;
  logic [31:0]             s_rdata_o;
  logic [1:0]              s_rresp_o;
  logic                    s_rvalid_o;
  logic                    s_rready_i;

  int          checks;
  int          errors;
  int          cycle_cnt;
  string       test_name;
  logic [15:0] thr_exp;

  gat_debugger_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: the tests were still running after %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic check_data(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: %s expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input gat_debug_pkg::axi_resp_e exp,
                            input gat_debug_pkg::axi_resp_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error %s: %s expected %s, actual %s (%b)", test_name, what,
               exp.name(), act.name(), act);
    end
  endtask

  // waits out the B channel with bready low for stall cycles, then accepts it
  task automatic finish_write(input int stall, output gat_debug_pkg::axi_resp_e resp);
    @(negedge clk);
    while (!s_bvalid_o) @(negedge clk);
    repeat (stall) @(negedge clk);
    resp = gat_debug_pkg::axi_resp_e'(s_bresp_o);
    @(posedge clk);
    s_bready_i <= 1'b1;
    @(posedge clk);
    s_bready_i <= 1'b0;
  endtask

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                            output gat_debug_pkg::axi_resp_e resp);
    @(posedge clk);
    s_awaddr_i  <= addr;
    s_wdata_i   <= data;
    s_wstrb_i   <= 4'hF;
    s_awvalid_i <= 1'b1;
    s_wvalid_i  <= 1'b1;
    @(negedge clk);
    while (!(s_awready_o && s_wready_o)) @(negedge clk);
    @(posedge clk);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    finish_write(0, resp);
  endtask

  task automatic axil_read(input logic [7:0] addr, input int stall, output logic [31:0] data,
                           output gat_debug_pkg::axi_resp_e resp);
    @(posedge clk);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    @(negedge clk);
    while (!s_arready_o) @(negedge clk);
    @(posedge clk);
    s_arvalid_i <= 1'b0;
    @(negedge clk);
    while (!s_rvalid_o) @(negedge clk);
    repeat (stall) begin
      @(negedge clk);
      if (!s_rvalid_o || s_arready_o) begin
        errors++;
        $display("%s: read channel left the data phase while rready was low", test_name);
      end
    end
    data = s_rdata_o;
    resp = gat_debug_pkg::axi_resp_e'(s_rresp_o);
    @(posedge clk);
    s_rready_i <= 1'b1;
    @(posedge clk);
    s_rready_i <= 1'b0;
  endtask

  task automatic read_expect(input string what, input logic [7:0] addr, input logic [31:0] exp,
                             input gat_debug_pkg::axi_resp_e exp_resp, input int stall);
    logic [31:0]              data;
    gat_debug_pkg::axi_resp_e resp;
    axil_read(addr, stall, data, resp);
    check_data(what, exp, data);
    check_resp({what, " rresp"}, exp_resp, resp);
  endtask

  task automatic write_expect(input string what, input logic [7:0] addr, input logic [31:0] data,
                              input gat_debug_pkg::axi_resp_e exp_resp);
    gat_debug_pkg::axi_resp_e resp;
    axil_write(addr, data, resp);
    check_resp({what, " bresp"}, exp_resp, resp);
  endtask

  // index follows the flag word order, spmm valid at bit 0 up to aggr ready at bit 7
  task automatic pulse_stage(input int idx);
    @(posedge clk);
    case (idx)
      0: spmm_vld_i <= 1'b1;
      1: spmm_rdy_i <= 1'b1;
      2: dmvm_vld_i <= 1'b1;
      3: dmvm_rdy_i <= 1'b1;
      4: sm_vld_i   <= 1'b1;
      5: sm_rdy_i   <= 1'b1;
      6: aggr_vld_i <= 1'b1;
      default: aggr_rdy_i <= 1'b1;
    endcase
    @(posedge clk);
    {spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i} <= 4'd0;
    {sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i}     <= 4'd0;
  endtask

  task automatic feat_write(input logic [15:0] addr, input logic ena);
    @(posedge clk);
    feat_bram_ena_i   <= ena;
    feat_bram_addra_i <= addr;
    @(posedge clk);
    feat_bram_ena_i <= 1'b0;
  endtask

  // lane 2 carries the given value, the other lanes carry random filler
  task automatic sppe_event(input logic [13:0] addr, input logic rdy, input logic [11:0] lane2);
    logic [15:0][11:0] lanes;
    logic [31:0]       r;
    for (int i = 0; i < 16; i++) begin
      r = $urandom;
      lanes[i] = r[11:0];
    end
    lanes[2] = lane2;
    @(posedge clk);
    wh_bram_addra_i <= addr;
    spmm_rdy_i      <= rdy;
    sppe_i          <= lanes;
    @(posedge clk);
    spmm_rdy_i <= 1'b0;
    sppe_i     <= '0;
  endtask

  task automatic test_reset_values();
    test_name = "reset_values";
    read_expect("ID", gat_debug_pkg::ID, ID_EXP, gat_debug_pkg::OKAY, 0);
    read_expect("FLAGS", gat_debug_pkg::FLAGS, 32'd0, gat_debug_pkg::OKAY, 0);
    read_expect("SMCNT_LO", gat_debug_pkg::SMCNT_LO, 32'd0, gat_debug_pkg::OKAY, 0);
    read_expect("SMCNT_HI", gat_debug_pkg::SMCNT_HI, 32'd0, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_A", gat_debug_pkg::CAP_A, 32'd0, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_B", gat_debug_pkg::CAP_B, 32'd0, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_ADDR_A", gat_debug_pkg::CAP_ADDR_A, 32'd10, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_ADDR_B", gat_debug_pkg::CAP_ADDR_B, 32'd20, gat_debug_pkg::OKAY, 0);
    read_expect("FEAT_THR", gat_debug_pkg::FEAT_THR, 32'd43328, gat_debug_pkg::OKAY, 0);
    read_expect("CTRL", gat_debug_pkg::CTRL, 32'd0, gat_debug_pkg::OKAY, 0);
    read_expect("unmapped 0x30", 8'h30, 32'd0, gat_debug_pkg::SLVERR, 0);
    write_expect("write to ID", gat_debug_pkg::ID, 32'hFFFF_FFFF, gat_debug_pkg::SLVERR);
    read_expect("ID after write", gat_debug_pkg::ID, ID_EXP, gat_debug_pkg::OKAY, 0);
  endtask

  task automatic test_stage_flags();
    logic [31:0] exp;
    test_name = "stage_flags";
    exp = 32'd0;
    for (int i = 0; i < 8; i++) begin
      pulse_stage(i);
      exp = exp | (32'd1 << i);
      read_expect($sformatf("FLAGS after input %0d", i), gat_debug_pkg::FLAGS, exp,
                  gat_debug_pkg::OKAY, 0);
    end
    write_expect("clear flags", gat_debug_pkg::CTRL, 32'h1, gat_debug_pkg::OKAY);
    read_expect("FLAGS after clear", gat_debug_pkg::FLAGS, 32'd0, gat_debug_pkg::OKAY, 0);
    pulse_stage(5);
    read_expect("FLAGS after sm ready", gat_debug_pkg::FLAGS, 32'h20, gat_debug_pkg::OKAY, 0);
  endtask

  task automatic test_feat_range();
    logic [31:0] r;
    test_name = "feat_range";
    r = $urandom;
    thr_exp = {1'b0, r[14:0]} | 16'h0100;
    write_expect("FEAT_THR", gat_debug_pkg::FEAT_THR, {16'd0, thr_exp}, gat_debug_pkg::OKAY);
    read_expect("FEAT_THR", gat_debug_pkg::FEAT_THR, {16'd0, thr_exp}, gat_debug_pkg::OKAY, 0);
    write_expect("clear flags", gat_debug_pkg::CTRL, 32'h1, gat_debug_pkg::OKAY);
    feat_write(thr_exp - 16'd1, 1'b1);
    feat_write(thr_exp >> 1, 1'b1);
    read_expect("FLAGS below threshold", gat_debug_pkg::FLAGS, 32'd0, gat_debug_pkg::OKAY, 0);
    feat_write(thr_exp, 1'b0);
    read_expect("FLAGS with ena low", gat_debug_pkg::FLAGS, 32'd0, gat_debug_pkg::OKAY, 0);
    feat_write(thr_exp, 1'b1);
    read_expect("FLAGS at threshold", gat_debug_pkg::FLAGS, 32'h100, gat_debug_pkg::OKAY, 0);
  endtask

  task automatic test_sm_count();
    int n;
    int remaining;
    int burst;
    test_name = "sm_count";
    write_expect("clear count", gat_debug_pkg::CTRL, 32'h2, gat_debug_pkg::OKAY);
    read_expect("SMCNT_LO cleared", gat_debug_pkg::SMCNT_LO, 32'd0, gat_debug_pkg::OKAY, 0);
    n = $urandom_range(40, 10);
    remaining = n;
    while (remaining > 0) begin
      burst = $urandom_range(6, 1);
      if (burst > remaining) begin
        burst = remaining;
      end
      remaining = remaining - burst;
      @(posedge clk);
      sm_vld_i <= 1'b1;
      repeat (burst) @(posedge clk);
      sm_vld_i <= 1'b0;
      repeat ($urandom_range(3, 1)) @(posedge clk);
    end
    read_expect("SMCNT_LO", gat_debug_pkg::SMCNT_LO, n, gat_debug_pkg::OKAY, 0);
    read_expect("SMCNT_HI", gat_debug_pkg::SMCNT_HI, 32'd0, gat_debug_pkg::OKAY, 0);
    write_expect("clear count", gat_debug_pkg::CTRL, 32'h2, gat_debug_pkg::OKAY);
    read_expect("SMCNT_LO after clear", gat_debug_pkg::SMCNT_LO, 32'd0, gat_debug_pkg::OKAY, 0);
  endtask

  task automatic test_sppe_capture();
    logic [31:0] r;
    logic [13:0] addr_a;
    logic [13:0] addr_b;
    logic [11:0] va;
    logic [11:0] vb;
    test_name = "sppe_capture";
    r = $urandom;
    addr_a = {1'b0, r[12:0]} & 14'h1FFF;
    addr_b = addr_a + 14'd1 + {3'd0, r[23:13]};
    write_expect("CAP_ADDR_A", gat_debug_pkg::CAP_ADDR_A, {18'd0, addr_a}, gat_debug_pkg::OKAY);
    write_expect("CAP_ADDR_B", gat_debug_pkg::CAP_ADDR_B, {18'd0, addr_b}, gat_debug_pkg::OKAY);
    read_expect("CAP_ADDR_A", gat_debug_pkg::CAP_ADDR_A, {18'd0, addr_a}, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_ADDR_B", gat_debug_pkg::CAP_ADDR_B, {18'd0, addr_b}, gat_debug_pkg::OKAY, 0);
    r = $urandom;
    va = r[11:0];
    vb = r[27:16];
    sppe_event(addr_a, 1'b1, va);
    read_expect("CAP_A", gat_debug_pkg::CAP_A, {20'd0, va}, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_B untouched", gat_debug_pkg::CAP_B, 32'd0, gat_debug_pkg::OKAY, 0);
    sppe_event(addr_b, 1'b1, vb);
    read_expect("CAP_B", gat_debug_pkg::CAP_B, {20'd0, vb}, gat_debug_pkg::OKAY, 0);
    // new filler on the other lanes first, then a match without spmm ready and a miss
    sppe_event(addr_a, 1'b1, va);
    sppe_event(addr_a, 1'b0, ~va);
    sppe_event(addr_b + 14'd1, 1'b1, ~vb);
    read_expect("CAP_A kept", gat_debug_pkg::CAP_A, {20'd0, va}, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_B kept", gat_debug_pkg::CAP_B, {20'd0, vb}, gat_debug_pkg::OKAY, 0);
    write_expect("clear captures", gat_debug_pkg::CTRL, 32'h4, gat_debug_pkg::OKAY);
    read_expect("CAP_A cleared", gat_debug_pkg::CAP_A, 32'd0, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_B cleared", gat_debug_pkg::CAP_B, 32'd0, gat_debug_pkg::OKAY, 0);
  endtask

  task automatic test_backpressure();
    logic [31:0]              r;
    gat_debug_pkg::axi_resp_e resp;
    test_name = "backpressure";
    read_expect("ID with rready low", gat_debug_pkg::ID, ID_EXP, gat_debug_pkg::OKAY, 6);
    read_expect("FEAT_THR with rready low", gat_debug_pkg::FEAT_THR, {16'd0, thr_exp},
                gat_debug_pkg::OKAY, 3);
    r = $urandom;
    @(posedge clk);
    s_awaddr_i  <= gat_debug_pkg::CAP_ADDR_A;
    s_wdata_i   <= {18'd0, r[13:0]};
    s_awvalid_i <= 1'b1;
    s_wvalid_i  <= 1'b1;
    @(negedge clk);
    while (!s_awready_o) @(negedge clk);
    @(posedge clk);
    s_awaddr_i <= gat_debug_pkg::CAP_ADDR_B;
    s_wdata_i  <= {18'd0, r[29:16]};
    repeat (5) begin
      @(negedge clk);
      if (!s_bvalid_o || s_awready_o || s_wready_o) begin
        errors++;
        $display("%s: a second write was accepted while bready was low", test_name);
      end
    end
    finish_write(0, resp);
    check_resp("first write bresp", gat_debug_pkg::OKAY, resp);
    @(negedge clk);
    while (!s_awready_o) @(negedge clk);
    @(posedge clk);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    finish_write(4, resp);
    check_resp("second write bresp", gat_debug_pkg::OKAY, resp);
    read_expect("CAP_ADDR_A", gat_debug_pkg::CAP_ADDR_A, {18'd0, r[13:0]}, gat_debug_pkg::OKAY, 0);
    read_expect("CAP_ADDR_B", gat_debug_pkg::CAP_ADDR_B, {18'd0, r[29:16]}, gat_debug_pkg::OKAY, 0);
  endtask

  initial begin
    void'($urandom(32'h29b2_12b9));
    checks = 0;
    errors = 0;
    cycle_cnt = 0;
    thr_exp = 16'd0;
    rst_n = 1'b0;
    {spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i} = 4'd0;
    {sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i} = 4'd0;
    wh_bram_addra_i = 14'd0;
    sppe_i = '0;
    feat_bram_ena_i = 1'b0;
    feat_bram_addra_i = 16'd0;
    {s_awaddr_i, s_awvalid_i, s_wdata_i, s_wstrb_i, s_wvalid_i, s_bready_i} = '0;
    {s_araddr_i, s_arvalid_i, s_rready_i} = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (!s_arready_o || s_awready_o || s_wready_o || s_rvalid_o || s_bvalid_o) begin
      errors++;
      $display("the AXI handshake outputs do not have their reset values");
    end
    test_reset_values();
    test_stage_flags();
    test_feat_range();
    test_sm_count();
    test_sppe_capture();
    test_backpressure();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
source/gat_debug_pkg.sv
source/debug_bus_if.sv
source/stage_flag_monitor.sv
source/sppe_event_monitor.sv
source/debug_axil_regs.sv
source/gat_debugger_top.sv
test/tb_gat_debugger.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_gat_debugger -o tb_gat_debugger
out=$(./obj_dir/tb_gat_debugger)
echo "$out"
if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
